//--- common/cdb_pkg.sv
/*
 * cdb_pkg
 * Shared types and constants for the completion stage and the
 * common data bus (CDB) listeners.
 */

package cdb_pkg;

   //////////////////////////////////////////////////
   // tags and payload
   //////////////////////////////////////////////////

   // RS tag, doubles as the ROB index
   typedef logic [4:0] tag_t;

   // all ones means nothing on the bus
   localparam tag_t rstag_null = 5'h1f;

   // result value
   typedef logic [63:0] value_t;

   // next pc of the instruction
   typedef logic [63:0] npc_t;

   //////////////////////////////////////////////////
   // branch bookkeeping
   //////////////////////////////////////////////////

   // bit 1 is branch, bit 0 is taken
   typedef logic [1:0] br_result_t;

   // width of the PHT index
   localparam int history_bits = 8;

   typedef logic [history_bits-1:0] pht_index_t;

endpackage

//--- common/cdb_if.sv
/*
 * cdb_if
 * One completion or broadcast lane. src drives the lane,
 * dst reads it.
 */

`timescale 1ns/1ps

interface cdb_if;
   import cdb_pkg::*;

   tag_t       tag;
   value_t     value;
   npc_t       npc;
   logic       mispredict;
   br_result_t branch_result;
   pht_index_t pht_index;
   logic       valid;

   // producer side
   modport src (
      output tag, value, npc, mispredict, branch_result, pht_index, valid
   );

   // listener side
   modport dst (
      input tag, value, npc, mispredict, branch_result, pht_index, valid
   );

endinterface

//--- src/ex_cm_latch.sv
/*
 * ex_cm_latch
 * Pipeline register between execute and complete for both lanes.
 * Valids clear on reset or flush; payload is held as is.
 */

`timescale 1ns/1ps

module ex_cm_latch (
   input  logic                  clock,
   input  logic                  rst,
   input  logic                  flush,

   input  cdb_pkg::tag_t         ex_tag_1,
   input  cdb_pkg::value_t       ex_result_1,
   input  cdb_pkg::npc_t         ex_npc_1,
   input  logic                  ex_mispredict_1,
   input  cdb_pkg::br_result_t   ex_branch_result_1,
   input  cdb_pkg::pht_index_t   ex_pht_index_1,
   input  logic                  ex_valid_1,

   input  cdb_pkg::tag_t         ex_tag_2,
   input  cdb_pkg::value_t       ex_result_2,
   input  cdb_pkg::npc_t         ex_npc_2,
   input  logic                  ex_mispredict_2,
   input  cdb_pkg::br_result_t   ex_branch_result_2,
   input  cdb_pkg::pht_index_t   ex_pht_index_2,
   input  logic                  ex_valid_2,

   cdb_if.src                    ex_cm_1,
   cdb_if.src                    ex_cm_2
);

   // lane valids, killed by a mispredict flush
   always_ff @(posedge clock) begin
      if (rst || flush) begin
         ex_cm_1.valid <= 1'b0;
         ex_cm_2.valid <= 1'b0;
      end else begin
         ex_cm_1.valid <= ex_valid_1;
         ex_cm_2.valid <= ex_valid_2;
      end
   end

   // payload of both lanes
   always_ff @(posedge clock) begin
      ex_cm_1.tag           <= ex_tag_1;
      ex_cm_1.value         <= ex_result_1;
      ex_cm_1.npc           <= ex_npc_1;
      ex_cm_1.mispredict    <= ex_mispredict_1;
      ex_cm_1.branch_result <= ex_branch_result_1;
      ex_cm_1.pht_index     <= ex_pht_index_1;

      ex_cm_2.tag           <= ex_tag_2;
      ex_cm_2.value         <= ex_result_2;
      ex_cm_2.npc           <= ex_npc_2;
      ex_cm_2.mispredict    <= ex_mispredict_2;
      ex_cm_2.branch_result <= ex_branch_result_2;
      ex_cm_2.pht_index     <= ex_pht_index_2;
   end

endmodule

//--- src/cm_stage.sv
/*
 * cm_stage
 * Complete stage. Forms the two CDB lanes from the latched
 * execute results; purely combinational.
 */

`timescale 1ns/1ps

module cm_stage (
   cdb_if.dst ex_cm_1,
   cdb_if.dst ex_cm_2,
   cdb_if.src cdb_1,
   cdb_if.src cdb_2
);
   import cdb_pkg::*;

   //////////////////////////////////////////////////
   // lane 1
   //////////////////////////////////////////////////

   // idle lane shows the null tag and a zero value
   assign cdb_1.tag           = ex_cm_1.valid ? ex_cm_1.tag : rstag_null;
   assign cdb_1.value         = ex_cm_1.valid ? ex_cm_1.value : value_t'(0);

   // branch info passes through untouched
   assign cdb_1.npc           = ex_cm_1.npc;
   assign cdb_1.mispredict    = ex_cm_1.mispredict;
   assign cdb_1.branch_result = ex_cm_1.branch_result;
   assign cdb_1.pht_index     = ex_cm_1.pht_index;
   assign cdb_1.valid         = ex_cm_1.valid;

   //////////////////////////////////////////////////
   // lane 2
   //////////////////////////////////////////////////

   assign cdb_2.tag           = ex_cm_2.valid ? ex_cm_2.tag : rstag_null;
   assign cdb_2.value         = ex_cm_2.valid ? ex_cm_2.value : value_t'(0);

   assign cdb_2.npc           = ex_cm_2.npc;
   assign cdb_2.mispredict    = ex_cm_2.mispredict;
   assign cdb_2.branch_result = ex_cm_2.branch_result;
   assign cdb_2.pht_index     = ex_cm_2.pht_index;
   assign cdb_2.valid         = ex_cm_2.valid;

endmodule

//--- src/rs_wakeup.sv
/*
 * rs_wakeup
 * Reservation-station operand table. Entries wait on a source tag,
 * capture the value from the CDB and issue lowest ready first.
 */

`timescale 1ns/1ps

module rs_wakeup #(
   parameter int rs_depth = 4
) (
   input  logic              clock,
   input  logic              rst,
   input  logic              flush,
   input  logic              dispatch_valid,
   input  cdb_pkg::tag_t     dispatch_src_tag,
   input  cdb_pkg::tag_t     dispatch_dest_tag,
   cdb_if.dst                cdb_1,
   cdb_if.dst                cdb_2,
   output logic              rs_full,
   output logic              issue_valid,
   output cdb_pkg::tag_t     issue_dest_tag,
   output cdb_pkg::value_t   issue_operand
);
   import cdb_pkg::*;

   localparam int idx_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

   logic [rs_depth-1:0] entry_valid;
   logic [rs_depth-1:0] entry_ready;
   tag_t                entry_src_tag  [rs_depth];
   tag_t                entry_dest_tag [rs_depth];
   value_t              entry_operand  [rs_depth];

   logic [rs_depth-1:0] wake_1;
   logic [rs_depth-1:0] wake_2;
   logic [rs_depth-1:0] ready_mask;
   logic [idx_w-1:0]    free_idx;
   logic [idx_w-1:0]    issue_idx;
   logic                dispatch_ok;
   logic                dispatch_hit_1;
   logic                dispatch_hit_2;

   // priority pick, lowest index wins
   function automatic logic [idx_w-1:0] lowest_set(input logic [rs_depth-1:0] bits);
      logic [idx_w-1:0] idx;
      idx = '0;
      for (int i = rs_depth - 1; i >= 0; i--) begin
         if (bits[i])
            idx = idx_w'(i);
      end
      return idx;
   endfunction

   //////////////////////////////////////////////////
   // tag match and selection
   //////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < rs_depth; i++) begin
         wake_1[i] = entry_valid[i] && !entry_ready[i] && cdb_1.valid &&
                     (cdb_1.tag == entry_src_tag[i]);
         wake_2[i] = entry_valid[i] && !entry_ready[i] && cdb_2.valid &&
                     (cdb_2.tag == entry_src_tag[i]);
      end
   end

   // source broadcast in the dispatch cycle is caught directly
   assign dispatch_hit_1 = cdb_1.valid && (cdb_1.tag == dispatch_src_tag);
   assign dispatch_hit_2 = cdb_2.valid && (cdb_2.tag == dispatch_src_tag);

   assign ready_mask  = entry_valid & entry_ready;
   assign free_idx    = lowest_set(~entry_valid);
   assign issue_idx   = lowest_set(ready_mask);
   assign rs_full     = &entry_valid;
   assign dispatch_ok = dispatch_valid && !rs_full;

   // nothing leaves while the table is being flushed
   assign issue_valid    = (|ready_mask) && !flush;
   assign issue_dest_tag = entry_dest_tag[issue_idx];
   assign issue_operand  = entry_operand[issue_idx];

   //////////////////////////////////////////////////
   // entry state
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (rst || flush) begin
         entry_valid <= '0;
         entry_ready <= '0;
      end else begin
         entry_ready <= entry_ready | wake_1 | wake_2;
         if (issue_valid) begin
            entry_valid[issue_idx] <= 1'b0;
            entry_ready[issue_idx] <= 1'b0;
         end
         if (dispatch_ok) begin
            entry_valid[free_idx] <= 1'b1;
            entry_ready[free_idx] <= dispatch_hit_1 || dispatch_hit_2;
         end
      end
   end

   // operand capture, lane 1 has priority
   always_ff @(posedge clock) begin
      for (int i = 0; i < rs_depth; i++) begin
         if (wake_1[i])
            entry_operand[i] <= cdb_1.value;
         else if (wake_2[i])
            entry_operand[i] <= cdb_2.value;
      end
      if (dispatch_ok) begin
         entry_src_tag[free_idx]  <= dispatch_src_tag;
         entry_dest_tag[free_idx] <= dispatch_dest_tag;
         entry_operand[free_idx]  <= dispatch_hit_1 ? cdb_1.value : cdb_2.value;
      end
   end

endmodule

//--- src/rob_complete.sv
/*
 * rob_complete
 * ROB completion side. Marks entries done from the CDB, retires
 * the head in order and turns a retired mispredict into a flush.
 */

`timescale 1ns/1ps

module rob_complete #(
   parameter int rob_depth = 16
) (
   input  logic                  clock,
   input  logic                  rst,
   input  logic                  rob_alloc,
   output cdb_pkg::tag_t         rob_alloc_tag,
   output logic                  rob_full,
   cdb_if.dst                    cdb_1,
   cdb_if.dst                    cdb_2,
   output logic                  retire_valid,
   output cdb_pkg::tag_t         retire_tag,
   output cdb_pkg::value_t       retire_value,
   output cdb_pkg::npc_t         retire_npc,
   output cdb_pkg::br_result_t   retire_branch_result,
   output cdb_pkg::pht_index_t   retire_pht_index,
   output logic                  flush
);
   import cdb_pkg::*;

   localparam int ptr_w = (rob_depth > 1) ? $clog2(rob_depth) : 1;
   localparam int cnt_w = $clog2(rob_depth + 1);

   logic [ptr_w-1:0]     head;
   logic [ptr_w-1:0]     tail;
   logic [cnt_w-1:0]     count;
   logic [rob_depth-1:0] entry_done;

   value_t     entry_value      [rob_depth];
   npc_t       entry_npc        [rob_depth];
   logic       entry_mispredict [rob_depth];
   br_result_t entry_br_result  [rob_depth];
   pht_index_t entry_pht_index  [rob_depth];

   logic       hit_head_1;
   logic       hit_head_2;
   logic       head_done;
   logic       retire_now;
   logic       alloc_ok;

   // wrap at rob_depth, which need not be a power of two
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      return (p == ptr_w'(rob_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign rob_alloc_tag = tag_t'(tail);
   assign rob_full      = (count == cnt_w'(rob_depth));
   assign alloc_ok      = rob_alloc && !rob_full;

   // head may complete on the bus in the very cycle it retires
   assign hit_head_1 = cdb_1.valid && (cdb_1.tag == tag_t'(head));
   assign hit_head_2 = cdb_2.valid && (cdb_2.tag == tag_t'(head));
   assign head_done  = entry_done[head] || hit_head_1 || hit_head_2;
   assign retire_now = head_done && (count != '0) && !flush;

   //////////////////////////////////////////////////
   // pointers and done bits
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (rst) begin
         head         <= '0;
         tail         <= '0;
         count        <= '0;
         entry_done   <= '0;
         retire_valid <= 1'b0;
         flush        <= 1'b0;
      end else if (flush) begin
         // younger entries are wrong path, drop them all
         tail         <= head;
         count        <= '0;
         entry_done   <= '0;
         retire_valid <= 1'b0;
         flush        <= 1'b0;
      end else begin
         for (int i = 0; i < rob_depth; i++) begin
            if ((cdb_1.valid && cdb_1.tag == tag_t'(i)) ||
                (cdb_2.valid && cdb_2.tag == tag_t'(i)))
               entry_done[i] <= 1'b1;
         end
         if (retire_now) begin
            entry_done[head] <= 1'b0;
            head             <= ptr_inc(head);
         end
         if (alloc_ok)
            tail <= ptr_inc(tail);
         count        <= count + cnt_w'(alloc_ok) - cnt_w'(retire_now);
         retire_valid <= retire_now;
         flush        <= retire_now &&
                         (hit_head_1 ? cdb_1.mispredict :
                          hit_head_2 ? cdb_2.mispredict : entry_mispredict[head]);
      end
   end

   //////////////////////////////////////////////////
   // payload store and retire outputs
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      for (int i = 0; i < rob_depth; i++) begin
         if (cdb_1.valid && cdb_1.tag == tag_t'(i)) begin
            entry_value[i]      <= cdb_1.value;
            entry_npc[i]        <= cdb_1.npc;
            entry_mispredict[i] <= cdb_1.mispredict;
            entry_br_result[i]  <= cdb_1.branch_result;
            entry_pht_index[i]  <= cdb_1.pht_index;
         end else if (cdb_2.valid && cdb_2.tag == tag_t'(i)) begin
            entry_value[i]      <= cdb_2.value;
            entry_npc[i]        <= cdb_2.npc;
            entry_mispredict[i] <= cdb_2.mispredict;
            entry_br_result[i]  <= cdb_2.branch_result;
            entry_pht_index[i]  <= cdb_2.pht_index;
         end
      end
      retire_tag <= tag_t'(head);
      if (hit_head_1) begin
         retire_value         <= cdb_1.value;
         retire_npc           <= cdb_1.npc;
         retire_branch_result <= cdb_1.branch_result;
         retire_pht_index     <= cdb_1.pht_index;
      end else if (hit_head_2) begin
         retire_value         <= cdb_2.value;
         retire_npc           <= cdb_2.npc;
         retire_branch_result <= cdb_2.branch_result;
         retire_pht_index     <= cdb_2.pht_index;
      end else begin
         retire_value         <= entry_value[head];
         retire_npc           <= entry_npc[head];
         retire_branch_result <= entry_br_result[head];
         retire_pht_index     <= entry_pht_index[head];
      end
   end

endmodule

//--- src/complete_top.sv
/*
 * complete_top
 * Completion and broadcast slice: execute latch, complete stage,
 * RS wakeup table and ROB completion side.
 */

`timescale 1ns/1ps

module complete_top #(
   parameter int rs_depth  = 4,
   parameter int rob_depth = 16
) (
   input  logic                  clock,
   input  logic                  rst,

   input  cdb_pkg::tag_t         ex_tag_1,
   input  cdb_pkg::value_t       ex_result_1,
   input  cdb_pkg::npc_t         ex_npc_1,
   input  logic                  ex_mispredict_1,
   input  cdb_pkg::br_result_t   ex_branch_result_1,
   input  cdb_pkg::pht_index_t   ex_pht_index_1,
   input  logic                  ex_valid_1,

   input  cdb_pkg::tag_t         ex_tag_2,
   input  cdb_pkg::value_t       ex_result_2,
   input  cdb_pkg::npc_t         ex_npc_2,
   input  logic                  ex_mispredict_2,
   input  cdb_pkg::br_result_t   ex_branch_result_2,
   input  cdb_pkg::pht_index_t   ex_pht_index_2,
   input  logic                  ex_valid_2,

   input  logic                  dispatch_valid,
   input  cdb_pkg::tag_t         dispatch_src_tag,
   input  cdb_pkg::tag_t         dispatch_dest_tag,
   input  logic                  rob_alloc,

   output cdb_pkg::tag_t         rob_alloc_tag,
   output logic                  rob_full,
   output logic                  rs_full,

   // register file writeback
   output cdb_pkg::tag_t         cdb_tag_1,
   output cdb_pkg::value_t       cdb_value_1,
   output logic                  cdb_valid_1,
   output cdb_pkg::tag_t         cdb_tag_2,
   output cdb_pkg::value_t       cdb_value_2,
   output logic                  cdb_valid_2,

   output logic                  issue_valid,
   output cdb_pkg::tag_t         issue_dest_tag,
   output cdb_pkg::value_t       issue_operand,

   output logic                  retire_valid,
   output cdb_pkg::tag_t         retire_tag,
   output cdb_pkg::value_t       retire_value,
   output cdb_pkg::npc_t         retire_npc,
   output cdb_pkg::br_result_t   retire_branch_result,
   output cdb_pkg::pht_index_t   retire_pht_index,
   output logic                  flush
);

   // execute to complete, then the broadcast lanes
   cdb_if ex_cm_1 ();
   cdb_if ex_cm_2 ();
   cdb_if cdb_1 ();
   cdb_if cdb_2 ();

   ex_cm_latch u_ex_cm_latch (
      .clock, .rst, .flush,
      .ex_tag_1, .ex_result_1, .ex_npc_1, .ex_mispredict_1,
      .ex_branch_result_1, .ex_pht_index_1, .ex_valid_1,
      .ex_tag_2, .ex_result_2, .ex_npc_2, .ex_mispredict_2,
      .ex_branch_result_2, .ex_pht_index_2, .ex_valid_2,
      .ex_cm_1 (ex_cm_1.src),
      .ex_cm_2 (ex_cm_2.src)
   );

   cm_stage u_cm_stage (
      .ex_cm_1 (ex_cm_1.dst),
      .ex_cm_2 (ex_cm_2.dst),
      .cdb_1   (cdb_1.src),
      .cdb_2   (cdb_2.src)
   );

   rs_wakeup #(.rs_depth(rs_depth)) u_rs_wakeup (
      .clock, .rst, .flush,
      .dispatch_valid, .dispatch_src_tag, .dispatch_dest_tag,
      .cdb_1 (cdb_1.dst),
      .cdb_2 (cdb_2.dst),
      .rs_full, .issue_valid, .issue_dest_tag, .issue_operand
   );

   rob_complete #(.rob_depth(rob_depth)) u_rob_complete (
      .clock, .rst, .rob_alloc, .rob_alloc_tag, .rob_full,
      .cdb_1 (cdb_1.dst),
      .cdb_2 (cdb_2.dst),
      .retire_valid, .retire_tag, .retire_value, .retire_npc,
      .retire_branch_result, .retire_pht_index, .flush
   );

   assign cdb_tag_1   = cdb_1.tag;
   assign cdb_value_1 = cdb_1.value;
   assign cdb_valid_1 = cdb_1.valid;
   assign cdb_tag_2   = cdb_2.tag;
   assign cdb_value_2 = cdb_2.value;
   assign cdb_valid_2 = cdb_2.valid;

endmodule

//--- verification/tb_complete.sv
/*
 * tb_complete
 * Table-driven testbench for the completion slice. A cycle model of
 * the CDB, ROB order and RS contents predicts every output.
 */

`timescale 1ns/1ps

module tb_complete;
   import cdb_pkg::*;

   localparam int rs_depth  = 4;
   localparam int rob_depth = 16;

   typedef struct packed {
      logic [3:0] test;
      logic       alloc;
      logic       v1;
      logic [4:0] t1;
      logic       m1;
      logic       v2;
      logic [4:0] t2;
      logic       m2;
      logic       disp;
      logic [4:0] src;
      logic [4:0] dst;
      logic [4:0] xt1;
      logic [4:0] xt2;
   } row_t;

   logic clock, rst;
   tag_t ex_tag_1, ex_tag_2, dispatch_src_tag, dispatch_dest_tag;
   value_t ex_result_1, ex_result_2;
   npc_t ex_npc_1, ex_npc_2;
   logic ex_mispredict_1, ex_mispredict_2, ex_valid_1, ex_valid_2;
   br_result_t ex_branch_result_1, ex_branch_result_2;
   pht_index_t ex_pht_index_1, ex_pht_index_2;
   logic dispatch_valid, rob_alloc;
   tag_t rob_alloc_tag, cdb_tag_1, cdb_tag_2, issue_dest_tag, retire_tag;
   logic rob_full, rs_full, cdb_valid_1, cdb_valid_2, issue_valid, retire_valid, flush;
   value_t cdb_value_1, cdb_value_2, issue_operand, retire_value;
   npc_t retire_npc;
   br_result_t retire_branch_result;
   pht_index_t retire_pht_index;

   row_t rows[$];
   int errors, test_errors, tests_passed, tests_failed, cycles;

   //////////////////////////////////////////////////
   // reference model state
   //////////////////////////////////////////////////

   // lanes as seen on the CDB in the current cycle
   logic l_v[2], l_mis[2];
   tag_t l_t[2];
   value_t l_val[2];
   npc_t l_npc[2];
   br_result_t l_br[2];
   pht_index_t l_pht[2];
   // ROB
   int rob_q[$];
   int rob_head, rob_tail;
   bit [31:0] done;
   value_t st_val[32];
   npc_t st_npc[32];
   br_result_t st_br[32];
   pht_index_t st_pht[32];
   logic st_mis[32];
   logic m_retire, m_flush;
   int r_tag;
   value_t r_val;
   npc_t r_npc;
   br_result_t r_br;
   pht_index_t r_pht;
   // RS
   bit rs_v[rs_depth], rs_r[rs_depth];
   tag_t rs_src[rs_depth], rs_dst[rs_depth];
   value_t rs_op[rs_depth];

   complete_top #(.rs_depth(rs_depth), .rob_depth(rob_depth)) dut0 (.*);

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // run limit follows the table length
   initial begin
      cycles = 0;
      while (cycles <= rows.size() * 4 + 50) begin
         @(posedge clock);
         cycles++;
      end
      $display("timeout: the run went past %0d cycles", rows.size() * 4 + 50);
      $display("TEST FAIL");
      $finish;
   end

   task automatic add_row(input int test, input int alloc, input int v1, input int t1,
                          input int m1, input int v2, input int t2, input int m2,
                          input int disp, input int src, input int dst,
                          input int xt1, input int xt2);
      row_t r;
      r.test = 4'(test);
      r.alloc = 1'(alloc);
      r.v1 = 1'(v1);
      r.t1 = 5'(t1);
      r.m1 = 1'(m1);
      r.v2 = 1'(v2);
      r.t2 = 5'(t2);
      r.m2 = 1'(m2);
      r.disp = 1'(disp);
      r.src = 5'(src);
      r.dst = 5'(dst);
      r.xt1 = 5'(xt1);
      r.xt2 = 5'(xt2);
      rows.push_back(r);
   endtask

   task automatic idle(input int test, input int n);
      for (int i = 0; i < n; i++)
         add_row(test, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Error: %s got %h expected %h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   function automatic int first_free();
      for (int i = 0; i < rs_depth; i++)
         if (!rs_v[i])
            return i;
      return -1;
   endfunction

   function automatic int first_ready();
      for (int i = 0; i < rs_depth; i++)
         if (rs_v[i] && rs_r[i])
            return i;
      return -1;
   endfunction

   task automatic drive_row(input row_t r);
      ex_valid_1 = r.v1;
      ex_tag_1 = r.t1;
      ex_mispredict_1 = r.m1;
      ex_result_1 = {$urandom, $urandom};
      ex_npc_1 = {$urandom, $urandom};
      ex_branch_result_1 = 2'($urandom);
      ex_pht_index_1 = 8'($urandom);
      ex_valid_2 = r.v2;
      ex_tag_2 = r.t2;
      ex_mispredict_2 = r.m2;
      ex_result_2 = {$urandom, $urandom};
      ex_npc_2 = {$urandom, $urandom};
      ex_branch_result_2 = 2'($urandom);
      ex_pht_index_2 = 8'($urandom);
      dispatch_valid = r.disp;
      dispatch_src_tag = r.src;
      dispatch_dest_tag = r.dst;
      rob_alloc = r.alloc;
   endtask

   // advance the model across one clock edge
   task automatic step_model();
      int fi;
      int tg;
      bit full;
      bit hit1;
      bit hit2;
      if (m_flush) begin
         rob_q.delete();
         rob_tail = rob_head;
         done = '0;
         m_retire = 1'b0;
         m_flush = 1'b0;
         for (int i = 0; i < rs_depth; i++) begin
            rs_v[i] = 1'b0;
            rs_r[i] = 1'b0;
         end
         l_v[0] = 1'b0;
         l_v[1] = 1'b0;
      end else begin
         // lane 2 first so lane 1 overwrites it
         for (int k = 1; k >= 0; k--) begin
            if (l_v[k] && int'(l_t[k]) < rob_depth) begin
               tg = int'(l_t[k]);
               done[tg] = 1'b1;
               st_val[tg] = l_val[k];
               st_npc[tg] = l_npc[k];
               st_br[tg] = l_br[k];
               st_pht[tg] = l_pht[k];
               st_mis[tg] = l_mis[k];
            end
         end
         full = (rob_q.size() == rob_depth);
         m_retire = 1'b0;
         m_flush = 1'b0;
         if (rob_q.size() > 0 && done[rob_q[0]]) begin
            tg = rob_q.pop_front();
            done[tg] = 1'b0;
            m_retire = 1'b1;
            m_flush = st_mis[tg];
            r_tag = tg;
            r_val = st_val[tg];
            r_npc = st_npc[tg];
            r_br = st_br[tg];
            r_pht = st_pht[tg];
            rob_head = (rob_head + 1) % rob_depth;
         end
         if (rob_alloc && !full) begin
            rob_q.push_back(rob_tail);
            rob_tail = (rob_tail + 1) % rob_depth;
         end

         // RS: issue, wakeup, dispatch
         fi = first_free();
         tg = first_ready();
         if (tg >= 0) begin
            rs_v[tg] = 1'b0;
            rs_r[tg] = 1'b0;
         end
         for (int i = 0; i < rs_depth; i++) begin
            if (rs_v[i] && !rs_r[i]) begin
               if (l_v[0] && l_t[0] == rs_src[i]) begin
                  rs_r[i] = 1'b1;
                  rs_op[i] = l_val[0];
               end else if (l_v[1] && l_t[1] == rs_src[i]) begin
                  rs_r[i] = 1'b1;
                  rs_op[i] = l_val[1];
               end
            end
         end
         if (dispatch_valid && fi >= 0) begin
            hit1 = l_v[0] && l_t[0] == dispatch_src_tag;
            hit2 = l_v[1] && l_t[1] == dispatch_src_tag;
            rs_v[fi] = 1'b1;
            rs_r[fi] = hit1 || hit2;
            rs_src[fi] = dispatch_src_tag;
            rs_dst[fi] = dispatch_dest_tag;
            rs_op[fi] = hit1 ? l_val[0] : l_val[1];
         end

         l_v[0] = ex_valid_1;
         l_t[0] = ex_tag_1;
         l_val[0] = ex_result_1;
         l_npc[0] = ex_npc_1;
         l_br[0] = ex_branch_result_1;
         l_pht[0] = ex_pht_index_1;
         l_mis[0] = ex_mispredict_1;
         l_v[1] = ex_valid_2;
         l_t[1] = ex_tag_2;
         l_val[1] = ex_result_2;
         l_npc[1] = ex_npc_2;
         l_br[1] = ex_branch_result_2;
         l_pht[1] = ex_pht_index_2;
         l_mis[1] = ex_mispredict_2;
      end
   endtask

   task automatic compare_outputs(input tag_t xt1, input tag_t xt2);
      int ii;
      bit all_v;
      ii = first_ready();
      all_v = 1'b1;
      for (int i = 0; i < rs_depth; i++)
         all_v = all_v && rs_v[i];
      check_value("cdb_tag_1", 64'(cdb_tag_1), 64'(xt1));
      check_value("cdb_tag_2", 64'(cdb_tag_2), 64'(xt2));
      check_value("cdb_valid_1", 64'(cdb_valid_1), 64'(l_v[0]));
      check_value("cdb_valid_2", 64'(cdb_valid_2), 64'(l_v[1]));
      check_value("cdb_value_1", cdb_value_1, l_v[0] ? l_val[0] : 64'h0);
      check_value("cdb_value_2", cdb_value_2, l_v[1] ? l_val[1] : 64'h0);
      check_value("rob_alloc_tag", 64'(rob_alloc_tag), 64'(rob_tail));
      check_value("rob_full", 64'(rob_full), 64'(rob_q.size() == rob_depth));
      check_value("rs_full", 64'(rs_full), 64'(all_v));
      check_value("issue_valid", 64'(issue_valid), 64'(ii >= 0 && !m_flush));
      if (ii >= 0 && !m_flush) begin
         check_value("issue_dest_tag", 64'(issue_dest_tag), 64'(rs_dst[ii]));
         check_value("issue_operand", issue_operand, rs_op[ii]);
      end
      check_value("retire_valid", 64'(retire_valid), 64'(m_retire));
      check_value("flush", 64'(flush), 64'(m_flush));
      if (m_retire) begin
         check_value("retire_tag", 64'(retire_tag), 64'(r_tag));
         check_value("retire_value", retire_value, r_val);
         check_value("retire_npc", retire_npc, r_npc);
         check_value("retire_branch_result", 64'(retire_branch_result), 64'(r_br));
         check_value("retire_pht_index", 64'(retire_pht_index), 64'(r_pht));
      end
   endtask

   task automatic report_test(input int test);
      $display("test %0d finished with %0d errors", test, test_errors);
      if (test_errors == 0)
         tests_passed++;
      else
         tests_failed++;
      test_errors = 0;
   endtask

   //////////////////////////////////////////////////
   // stimulus table and main loop
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(98838));
      errors = 0;
      test_errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      rst = 1'b1;
      drive_row('0);
      ex_tag_1 = rstag_null;
      ex_tag_2 = rstag_null;
      l_v[0] = 1'b0;
      l_v[1] = 1'b0;
      rob_head = 0;
      rob_tail = 0;
      done = '0;
      m_retire = 1'b0;
      m_flush = 1'b0;
      for (int i = 0; i < rs_depth; i++) begin
         rs_v[i] = 1'b0;
         rs_r[i] = 1'b0;
      end

      // null broadcast, basic retire
      add_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31);
      add_row(1, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 31, 1);
      idle(1, 2);
      // dual completion
      add_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(2, 0, 1, 3, 0, 1, 2, 0, 0, 0, 0, 3, 2);
      idle(2, 3);
      // younger tags first
      add_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(3, 0, 1, 6, 0, 0, 0, 0, 0, 0, 0, 6, 31);
      add_row(3, 0, 0, 0, 0, 1, 5, 0, 0, 0, 0, 31, 5);
      idle(3, 2);
      add_row(3, 0, 1, 4, 0, 0, 0, 0, 0, 0, 0, 4, 31);
      idle(3, 4);
      // wakeup, lane priority, rs_full
      add_row(4, 1, 0, 0, 0, 0, 0, 0, 1, 7, 21, 31, 31);
      add_row(4, 1, 0, 0, 0, 0, 0, 0, 1, 8, 22, 31, 31);
      add_row(4, 1, 0, 0, 0, 0, 0, 0, 1, 7, 23, 31, 31);
      add_row(4, 0, 0, 0, 0, 0, 0, 0, 1, 9, 24, 31, 31);
      add_row(4, 0, 0, 0, 0, 0, 0, 0, 1, 9, 25, 31, 31);
      add_row(4, 0, 1, 7, 0, 1, 7, 0, 0, 0, 0, 7, 7);
      add_row(4, 0, 1, 8, 0, 0, 0, 0, 0, 0, 0, 8, 31);
      add_row(4, 0, 0, 0, 0, 1, 9, 0, 0, 0, 0, 31, 9);
      idle(4, 6);
      // mispredicted branch at tag 10
      add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(5, 1, 0, 0, 0, 0, 0, 0, 1, 13, 26, 31, 31);
      add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(5, 0, 1, 12, 0, 1, 11, 0, 0, 0, 0, 12, 11);
      // waiting entry wakes on 13 as the branch retires
      add_row(5, 0, 1, 10, 1, 1, 13, 0, 0, 0, 0, 10, 13);
      idle(5, 1);
      // latched on the flush edge, so never broadcast
      add_row(5, 0, 1, 13, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 31, 31);
      idle(5, 3);

      repeat (4) @(posedge clock);
      #1;
      rst = 1'b0;
      // state right after reset
      compare_outputs(rstag_null, rstag_null);
      report_test(6);

      for (int r = 0; r < rows.size(); r++) begin
         if (r > 0 && rows[r].test != rows[r - 1].test)
            report_test(int'(rows[r - 1].test));
         drive_row(rows[r]);
         @(posedge clock);
         #1;
         step_model();
         compare_outputs(rows[r].xt1, rows[r].xt2);
      end
      report_test(int'(rows[rows.size() - 1].test));

      $display("tests passed %0d, tests failed %0d, errors %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- all.f
common/cdb_pkg.sv
common/cdb_if.sv
src/ex_cm_latch.sv
src/cm_stage.sv
src/rs_wakeup.sv
src/rob_complete.sv
src/complete_top.sv
verification/tb_complete.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_complete -o sim_complete \
   && ./obj_dir/sim_complete | grep "TEST PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
